//--- compile.f
+incdir+dv
hw/csr_pkg.sv
hw/csr_access_ctrl.sv
hw/csr_machine_regs.sv
hw/csr_perf_counters.sv
hw/csr_subsystem.sv
dv/csr_tb.sv

//--- Makefile
# Verilator build and run of the CSR subsystem testbench.
# The simulator's exit status is the test result.

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f compile.f --top-module csr_tb -Mdir obj_dir -o csr_tb
	./obj_dir/csr_tb

clean:
	rm -rf obj_dir

//--- dv/csr_tb_table.svh
// Access table for the CSR subsystem testbench, walked in order.
// Each row may first drive events or pulse the exception capture.
`ifndef CSR_TB_TABLE_SVH
`define CSR_TB_TABLE_SVH

localparam logic [1:0] do_plain   = 2'd0;  // access only
localparam logic [1:0] do_events  = 2'd1;  // arg cycles of load, store, ext first
localparam logic [1:0] do_capture = 2'd2;  // save_pc with pc = arg on commit edge

typedef struct packed {
  logic [1:0]       act;
  logic [31:0]      arg;
  logic [11:0]      addr;
  csr_pkg::csr_op_e op;
  logic [31:0]      wdata;
  logic [31:0]      exp_old;  // response data
  logic             exp_err;
} step_t;

localparam int n_steps = 46;

// columns: act, arg, addr, op, wdata, expected old value, expected error
localparam step_t steps [n_steps] = '{
  // reset values
  '{do_plain, 32'h0, csr_pkg::addr_mstatus, csr_pkg::op_none, 32'h0, 32'h6, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mscratch, csr_pkg::op_none, 32'h0, 32'h0, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_pcmr, csr_pkg::op_none, 32'h0, 32'h3, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_pcer, csr_pkg::op_none, 32'h0, 32'h0, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mcpuid, csr_pkg::op_none, 32'h0, csr_pkg::mcpuid_value, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mimpid, csr_pkg::op_none, 32'h0, csr_pkg::mimpid_value, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mhartid, csr_pkg::op_none, 32'h0, {22'b0, hart_id}, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mepc, csr_pkg::op_none, 32'h0, 32'h0, 1'b0},
  // write, set, clear on mscratch
  '{do_plain, 32'h0, csr_pkg::addr_mscratch, csr_pkg::op_write, 32'hA5A5_0F0F, 32'h0, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mscratch, csr_pkg::op_set, 32'h0000_F0F0, 32'hA5A5_0F0F, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mscratch, csr_pkg::op_clear, 32'hA5A5_0000, 32'hA5A5_FFFF, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mscratch, csr_pkg::op_none, 32'h0, 32'h0000_FFFF, 1'b0},
  // mstatus, only ie sticks
  '{do_plain, 32'h0, csr_pkg::addr_mstatus, csr_pkg::op_set, 32'h1, 32'h6, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mstatus, csr_pkg::op_write, 32'hFFFF_FFF0, 32'h7, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mstatus, csr_pkg::op_set, 32'hFFFF_FFFF, 32'h6, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mstatus, csr_pkg::op_clear, 32'h1, 32'h7, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mstatus, csr_pkg::op_none, 32'h0, 32'h6, 1'b0},
  // identity is read only
  '{do_plain, 32'h0, csr_pkg::addr_mhartid, csr_pkg::op_write, 32'h0, {22'b0, hart_id}, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mhartid, csr_pkg::op_none, 32'h0, {22'b0, hart_id}, 1'b0},
  // unmapped, 0x78b is past the last counter
  '{do_plain, 32'h0, 12'h123, csr_pkg::op_write, 32'hDEAD_BEEF, 32'h0, 1'b1},
  '{do_plain, 32'h0, 12'h78B, csr_pkg::op_set, 32'hFFFF_FFFF, 32'h0, 1'b1},
  '{do_plain, 32'h0, csr_pkg::addr_mscratch, csr_pkg::op_none, 32'h0, 32'h0000_FFFF, 1'b0},
  // capture against a same-cycle mepc write
  '{do_capture, 32'h1234, csr_pkg::addr_mepc, csr_pkg::op_write, 32'hBEEF, 32'h0, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mepc, csr_pkg::op_none, 32'h0, 32'h1234, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mepc, csr_pkg::op_write, 32'h2000, 32'h1234, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_mepc, csr_pkg::op_none, 32'h0, 32'h2000, 1'b0},
  // enable load, store and both externals
  '{do_plain, 32'h0, csr_pkg::addr_pcer, csr_pkg::op_write, 32'h660, 32'h0, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_pcer, csr_pkg::op_none, 32'h0, 32'h660, 1'b0},
  '{do_events, 32'd5, 12'h785, csr_pkg::op_none, 32'h0, 32'd5, 1'b0},
  '{do_plain, 32'h0, 12'h786, csr_pkg::op_none, 32'h0, 32'd5, 1'b0},
  '{do_plain, 32'h0, 12'h789, csr_pkg::op_none, 32'h0, 32'd5, 1'b0},
  '{do_plain, 32'h0, 12'h78A, csr_pkg::op_none, 32'h0, 32'd5, 1'b0},
  '{do_plain, 32'h0, 12'h780, csr_pkg::op_none, 32'h0, 32'h0, 1'b0},  // cycle, not enabled
  '{do_plain, 32'h0, 12'h781, csr_pkg::op_none, 32'h0, 32'h0, 1'b0},
  '{do_plain, 32'h0, 12'h784, csr_pkg::op_none, 32'h0, 32'h0, 1'b0},
  // saturate, then wrap
  '{do_plain, 32'h0, 12'h785, csr_pkg::op_write, 32'hFFFF_FFFF, 32'd5, 1'b0},
  '{do_events, 32'd3, 12'h785, csr_pkg::op_none, 32'h0, 32'hFFFF_FFFF, 1'b0},
  '{do_plain, 32'h0, 12'h786, csr_pkg::op_none, 32'h0, 32'd8, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_pcmr, csr_pkg::op_write, 32'h1, 32'h3, 1'b0},
  '{do_events, 32'd3, 12'h785, csr_pkg::op_none, 32'h0, 32'd2, 1'b0},
  '{do_plain, 32'h0, 12'h786, csr_pkg::op_none, 32'h0, 32'd11, 1'b0},
  // clear everything through 0x79f
  '{do_plain, 32'h0, csr_pkg::addr_pccr_all, csr_pkg::op_write, 32'h0, 32'h0, 1'b0},
  '{do_plain, 32'h0, 12'h785, csr_pkg::op_none, 32'h0, 32'h0, 1'b0},
  '{do_plain, 32'h0, 12'h786, csr_pkg::op_none, 32'h0, 32'h0, 1'b0},
  '{do_plain, 32'h0, 12'h78A, csr_pkg::op_none, 32'h0, 32'h0, 1'b0},
  '{do_plain, 32'h0, csr_pkg::addr_pcmr, csr_pkg::op_none, 32'h0, 32'h1, 1'b0}
};

`endif

//--- dv/csr_tb.sv
// Testbench for the CSR subsystem. Walks the access table with random
// response back-pressure and checks old values, errors, irq enable and epc.
// Inputs change on the falling clock edge, outputs are sampled there too.
`timescale 1ns/1ps
`default_nettype none

module csr_tb;

  localparam int         n_ext     = 2;
  localparam logic [9:0] hart_id   = 10'h025;
  localparam int         clk_half  = 20;   // 40 ns period

  logic              clk;
  logic              rst_n;
  logic              req_valid_i;
  logic              req_ready_o;
  logic [11:0]       req_addr_i;
  csr_pkg::csr_op_e  req_op_i;
  logic [31:0]       req_wdata_i;
  logic              rsp_valid_o;
  logic              rsp_ready_i;
  logic [31:0]       rsp_rdata_o;
  logic              rsp_err_o;
  logic              save_pc_i;
  logic [31:0]       pc_i;
  logic              retire_i;
  logic              ld_stall_i;
  logic              jr_stall_i;
  logic              imiss_i;
  logic              load_i;
  logic              store_i;
  logic              jump_i;
  logic              branch_i;
  logic [n_ext-1:0]  ext_events_i;
  logic              irq_enable_o;
  logic [31:0]       epc_o;

  `include "csr_tb_table.svh"

  // generous bound, no table row needs 40 cycles
  localparam int timeout_ns = (n_steps * 40 + 10) * 2 * clk_half;

  initial clk = 1'b0;
  always #(clk_half) clk = ~clk;

  csr_subsystem #(
    .N_EXT_EVENTS (n_ext),
    .HART_ID      (hart_id)
  ) u_csr_subsystem (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_addr_i   (req_addr_i),
    .req_op_i     (req_op_i),
    .req_wdata_i  (req_wdata_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_err_o    (rsp_err_o),
    .save_pc_i    (save_pc_i),
    .pc_i         (pc_i),
    .retire_i     (retire_i),
    .ld_stall_i   (ld_stall_i),
    .jr_stall_i   (jr_stall_i),
    .imiss_i      (imiss_i),
    .load_i       (load_i),
    .store_i      (store_i),
    .jump_i       (jump_i),
    .branch_i     (branch_i),
    .ext_events_i (ext_events_i),
    .irq_enable_o (irq_enable_o),
    .epc_o        (epc_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // new register value by operation
  function automatic logic [31:0] apply_op(input csr_pkg::csr_op_e op,
                                           input logic [31:0] old,
                                           input logic [31:0] wdata);
    case (op)
      csr_pkg::op_write: return wdata;
      csr_pkg::op_set:   return old | wdata;
      csr_pkg::op_clear: return old & ~wdata;
      default:           return old;
    endcase
  endfunction

  // enabled load, store and externals high for a number of cycles
  // retire and imiss ride along but stay unenabled, port idle
  task automatic drive_events(input int cycles);
    retire_i     = 1'b1;
    imiss_i      = 1'b1;
    load_i       = 1'b1;
    store_i      = 1'b1;
    ext_events_i = '1;
    repeat (cycles) @(negedge clk);
    retire_i     = 1'b0;
    imiss_i      = 1'b0;
    load_i       = 1'b0;
    store_i      = 1'b0;
    ext_events_i = '0;
    repeat (2) @(negedge clk);  // registered increment lands late
  endtask

  // one request/response pair, response held back 0 to 3 cycles
  task automatic run_access(input step_t s, output logic [31:0] old, output logic err);
    int stall;
    req_valid_i = 1'b1;
    req_addr_i  = s.addr;
    req_op_i    = s.op;
    req_wdata_i = s.wdata;
    while (!req_ready_o)
      @(negedge clk);
    @(negedge clk);               // accepted on the rising edge before
    req_valid_i = 1'b0;
    while (!rsp_valid_o)
      @(negedge clk);
    stall = $urandom % 4;
    repeat (stall) @(negedge clk);
    old         = rsp_rdata_o;    // frozen while stalled
    err         = rsp_err_o;
    rsp_ready_i = 1'b1;
    if (s.act == do_capture)
    begin
      save_pc_i = 1'b1;           // same edge as the commit
      pc_i      = s.arg;
    end
    @(negedge clk);
    rsp_ready_i = 1'b0;
    save_pc_i   = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] old;
    logic        err;
    logic        ie_exp;
    logic [31:0] new_val;
    void'($urandom(32'hc64c_e985));
    rst_n        = 1'b0;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    req_op_i     = csr_pkg::op_none;
    req_wdata_i  = '0;
    rsp_ready_i  = 1'b0;
    save_pc_i    = 1'b0;
    pc_i         = '0;
    retire_i     = 1'b0;
    ld_stall_i   = 1'b0;
    jr_stall_i   = 1'b0;
    imiss_i      = 1'b0;
    load_i       = 1'b0;
    store_i      = 1'b0;
    jump_i       = 1'b0;
    branch_i     = 1'b0;
    ext_events_i = '0;
    ie_exp       = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    for (int i = 0; i < n_steps; i++)
    begin
      if (steps[i].act == do_events)
        drive_events(steps[i].arg);
      run_access(steps[i], old, err);
      check_value($sformatf("step %0d old value", i), old, steps[i].exp_old);
      check_value($sformatf("step %0d error", i), {31'b0, err}, {31'b0, steps[i].exp_err});
      // irq enable tracks mstatus bit 0
      new_val = apply_op(steps[i].op, steps[i].exp_old, steps[i].wdata);
      if (steps[i].addr == csr_pkg::addr_mstatus && steps[i].op != csr_pkg::op_none)
        ie_exp = new_val[0];
      check_value($sformatf("step %0d irq enable", i), {31'b0, irq_enable_o},
                  {31'b0, ie_exp});
      if (steps[i].act == do_capture)
        check_value($sformatf("step %0d epc", i), epc_o, steps[i].arg);
    end

    $display("all tests passed");
    $finish;
  end

  // watchdog
  initial
  begin
    #(timeout_ns);
    $display("timeout at %0t ns: the access sequence never finished", $time);
    $display("tests failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- hw/csr_subsystem.sv
// Top of the CSR subsystem. Connects the access controller to the machine
// bank and the performance counter bank over a shared bank bus.
// One access in flight at a time, two cycles minimum per access.
`timescale 1ns/1ps
`default_nettype none

module csr_subsystem #(
  parameter int         N_EXT_EVENTS = 2,
  parameter logic [9:0] HART_ID      = 10'h025
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  // access port
  input  wire logic                    req_valid_i,
  output logic                         req_ready_o,
  input  wire logic [11:0]             req_addr_i,
  input  wire csr_pkg::csr_op_e        req_op_i,
  input  wire logic [31:0]             req_wdata_i,
  output logic                         rsp_valid_o,
  input  wire logic                    rsp_ready_i,
  output logic [31:0]                  rsp_rdata_o,
  output logic                         rsp_err_o,
  // pipeline side
  input  wire logic                    save_pc_i,
  input  wire logic [31:0]             pc_i,
  input  wire logic                    retire_i,
  input  wire logic                    ld_stall_i,
  input  wire logic                    jr_stall_i,
  input  wire logic                    imiss_i,
  input  wire logic                    load_i,
  input  wire logic                    store_i,
  input  wire logic                    jump_i,
  input  wire logic                    branch_i,
  input  wire logic [N_EXT_EVENTS-1:0] ext_events_i,
  output logic                         irq_enable_o,
  output logic [31:0]                  epc_o
);

  // bank bus
  logic [11:0] bank_addr;
  logic [31:0] bank_wdata;
  logic        bank_we;
  logic [31:0] mach_rdata;
  logic        mach_hit;
  logic [31:0] perf_rdata;
  logic        perf_hit;

  csr_access_ctrl u_access_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_addr_i   (req_addr_i),
    .req_op_i     (req_op_i),
    .req_wdata_i  (req_wdata_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_err_o    (rsp_err_o),
    .bank_addr_o  (bank_addr),
    .bank_wdata_o (bank_wdata),
    .bank_we_o    (bank_we),
    .mach_rdata_i (mach_rdata),
    .mach_hit_i   (mach_hit),
    .perf_rdata_i (perf_rdata),
    .perf_hit_i   (perf_hit)
  );

  csr_machine_regs #(
    .HART_ID (HART_ID)
  ) u_machine_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .addr_i       (bank_addr),
    .wdata_i      (bank_wdata),
    .we_i         (bank_we),
    .save_pc_i    (save_pc_i),
    .pc_i         (pc_i),
    .rdata_o      (mach_rdata),
    .hit_o        (mach_hit),
    .irq_enable_o (irq_enable_o),
    .epc_o        (epc_o)
  );

  csr_perf_counters #(
    .N_EXT_EVENTS (N_EXT_EVENTS)
  ) u_perf_counters (
    .clk          (clk),
    .rst_n        (rst_n),
    .addr_i       (bank_addr),
    .wdata_i      (bank_wdata),
    .we_i         (bank_we),
    .retire_i     (retire_i),
    .ld_stall_i   (ld_stall_i),
    .jr_stall_i   (jr_stall_i),
    .imiss_i      (imiss_i),
    .load_i       (load_i),
    .store_i      (store_i),
    .jump_i       (jump_i),
    .branch_i     (branch_i),
    .ext_events_i (ext_events_i),
    .rdata_o      (perf_rdata),
    .hit_o        (perf_hit)
  );

endmodule

`default_nettype wire

//--- hw/csr_perf_counters.sv
// Performance counter bank: one 32-bit counter per event, an event-enable
// register and a mode register {saturate, global enable}.
// Increments are registered, so an event counts two edges after it is seen.
`timescale 1ns/1ps
`default_nettype none

module csr_perf_counters #(
  parameter int N_EXT_EVENTS = 2
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic [11:0]             addr_i,
  input  wire logic [31:0]             wdata_i,
  input  wire logic                    we_i,
  // pipeline events, plain levels
  input  wire logic                    retire_i,
  input  wire logic                    ld_stall_i,
  input  wire logic                    jr_stall_i,
  input  wire logic                    imiss_i,
  input  wire logic                    load_i,
  input  wire logic                    store_i,
  input  wire logic                    jump_i,
  input  wire logic                    branch_i,
  input  wire logic [N_EXT_EVENTS-1:0] ext_events_i,
  output logic [31:0]                  rdata_o,
  output logic                         hit_o
);

  localparam int n_counters = csr_pkg::n_core_events + N_EXT_EVENTS;

  logic                         retire_q;   // retire seen last cycle
  logic [n_counters-1:0]        evt;
  logic [n_counters-1:0]        inc;
  logic [n_counters-1:0]        inc_q;
  logic [n_counters-1:0]        pcer_q;
  logic [1:0]                   pcmr_q;     // [1] saturate, [0] global enable
  logic [n_counters-1:0] [31:0] cnt_q;
  logic [n_counters-1:0] [31:0] cnt_n;
  logic                         sel_pcer;
  logic                         sel_pcmr;
  logic                         sel_cnt;    // one counter
  logic                         sel_all;    // 0x79f
  logic [4:0]                   cnt_idx;

  //////////////////////////////////////////////////////////////////////////
  // event vector
  //////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    evt                        = '0;
    evt[csr_pkg::evt_cycle]    = 1'b1;                   // every cycle
    evt[csr_pkg::evt_instr]    = retire_i;
    evt[csr_pkg::evt_ld_stall] = ld_stall_i & retire_q;  // hazards after retire
    evt[csr_pkg::evt_jr_stall] = jr_stall_i & retire_q;
    evt[csr_pkg::evt_imiss]    = imiss_i;                // fetch wait cycles
    evt[csr_pkg::evt_load]     = load_i;
    evt[csr_pkg::evt_store]    = store_i;
    evt[csr_pkg::evt_jump]     = jump_i & retire_q;
    evt[csr_pkg::evt_branch]   = branch_i & retire_q;
    evt[n_counters-1:csr_pkg::n_core_events] = ext_events_i;  // externals on top
  end

  assign inc = evt & pcer_q & {n_counters{pcmr_q[0]}};

  //////////////////////////////////////////////////////////////////////////
  // address decode and read
  //////////////////////////////////////////////////////////////////////////

  assign cnt_idx  = addr_i[4:0];
  assign sel_pcer = (addr_i == csr_pkg::addr_pcer);
  assign sel_pcmr = (addr_i == csr_pkg::addr_pcmr);
  assign sel_all  = (addr_i == csr_pkg::addr_pccr_all);
  // 0x780 window, only counters that exist
  assign sel_cnt  = (addr_i[11:5] == csr_pkg::addr_pccr_base[11:5]) &&
                    (32'(cnt_idx) < n_counters);
  assign hit_o    = sel_pcer | sel_pcmr | sel_cnt | sel_all;

  always_comb
  begin
    rdata_o = '0;  // 0x79f reads zero
    if (sel_pcer)
      rdata_o[n_counters-1:0] = pcer_q;
    else if (sel_pcmr)
      rdata_o[1:0] = pcmr_q;
    else if (sel_cnt)
      rdata_o = cnt_q[cnt_idx];
  end

  //////////////////////////////////////////////////////////////////////////
  // counter update
  //////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < n_counters; i++)
    begin
      cnt_n[i] = cnt_q[i];
      // stop at all ones when saturating, wrap otherwise
      if (inc_q[i] && (cnt_q[i] != '1 || !pcmr_q[1]))
        cnt_n[i] = cnt_q[i] + 32'd1;
      // a bank write wins over the increment
      if (we_i && (sel_all || (sel_cnt && cnt_idx == 5'(i))))
        cnt_n[i] = wdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      retire_q <= 1'b0;
      inc_q    <= '0;
      pcer_q   <= '0;     // nothing counts
      pcmr_q   <= 2'b11;  // enabled, saturating
      cnt_q    <= '0;
    end
    else
    begin
      retire_q <= retire_i;
      inc_q    <= inc;
      cnt_q    <= cnt_n;
      if (we_i && sel_pcer)
        pcer_q <= wdata_i[n_counters-1:0];
      if (we_i && sel_pcmr)
        pcmr_q <= wdata_i[1:0];
    end
  end

  // saturating counter parks at all ones until a bank write
  for (genvar g = 0; g < n_counters; g++)
  begin : g_sat_chk
    a_sat_hold: assert property (@(posedge clk) disable iff (!rst_n)
      pcmr_q[1] && !we_i && cnt_q[g] == '1 |=> cnt_q[g] == '1)
      else $error("saturating counter wrapped past all ones");
  end

endmodule

`default_nettype wire

//--- hw/csr_machine_regs.sv
// Machine-mode CSR bank: mstatus (interrupt enable only), mscratch, mepc
// with exception PC capture, and the read-only identity registers.
// Read data and hit are combinational from the bank address.
`timescale 1ns/1ps
`default_nettype none

module csr_machine_regs #(
  parameter logic [9:0] HART_ID = 10'h025
) (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic [11:0] addr_i,
  input  wire logic [31:0] wdata_i,
  input  wire logic        we_i,
  input  wire logic        save_pc_i,     // exception capture strobe
  input  wire logic [31:0] pc_i,
  output logic [31:0]      rdata_o,
  output logic             hit_o,
  output logic             irq_enable_o,
  output logic [31:0]      epc_o
);

  logic                   irq_enable_q;
  logic [31:0]            mscratch_q;
  logic [31:0]            mepc_q;
  csr_pkg::mstatus_word_u mstatus_rd;
  csr_pkg::mstatus_word_u mstatus_wr;

  // mstatus as seen by a read
  always_comb
  begin
    mstatus_rd.fld.zero = '0;
    mstatus_rd.fld.prv  = 2'b11;  // machine mode only
    mstatus_rd.fld.ie   = irq_enable_q;
  end

  assign mstatus_wr.raw = wdata_i;  // only the ie field is kept

  //////////////////////////////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (addr_i)
      csr_pkg::addr_mstatus:  rdata_o = mstatus_rd.raw;
      csr_pkg::addr_mscratch: rdata_o = mscratch_q;
      csr_pkg::addr_mepc:     rdata_o = mepc_q;
      csr_pkg::addr_mcpuid:   rdata_o = csr_pkg::mcpuid_value;
      csr_pkg::addr_mimpid:   rdata_o = csr_pkg::mimpid_value;
      csr_pkg::addr_mhartid:  rdata_o = {22'b0, HART_ID};
      default:                hit_o   = 1'b0;  // not ours
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      irq_enable_q <= 1'b0;
      mscratch_q   <= '0;
      mepc_q       <= '0;
    end
    else
    begin
      if (we_i && addr_i == csr_pkg::addr_mstatus)
        irq_enable_q <= mstatus_wr.fld.ie;
      if (we_i && addr_i == csr_pkg::addr_mscratch)
        mscratch_q <= wdata_i;
      // exception capture beats a csr write
      if (save_pc_i)
        mepc_q <= pc_i;
      else if (we_i && addr_i == csr_pkg::addr_mepc)
        mepc_q <= wdata_i;
      // identity registers ignore writes
    end
  end

  assign irq_enable_o = irq_enable_q;
  assign epc_o        = mepc_q;

  // captured pc shows up on epc_o the next cycle
  a_epc_capture: assert property (@(posedge clk) disable iff (!rst_n)
    save_pc_i |=> epc_o == $past(pc_i))
    else $error("mepc did not capture the exception pc");

endmodule

`default_nettype wire

//--- hw/csr_access_ctrl.sv
// Front end of the CSR subsystem. Takes one request at a time over a
// valid/ready port, answers one cycle later with the old value and commits
// the read-modify-write result to the banks on the response handshake.
`timescale 1ns/1ps
`default_nettype none

module csr_access_ctrl (
  input  wire logic               clk,
  input  wire logic               rst_n,
  // request channel
  input  wire logic               req_valid_i,
  output logic                    req_ready_o,
  input  wire logic [11:0]        req_addr_i,
  input  wire csr_pkg::csr_op_e   req_op_i,
  input  wire logic [31:0]        req_wdata_i,
  // response channel
  output logic                    rsp_valid_o,
  input  wire logic               rsp_ready_i,
  output logic [31:0]             rsp_rdata_o,
  output logic                    rsp_err_o,
  // bank bus
  output logic [11:0]             bank_addr_o,
  output logic [31:0]             bank_wdata_o,
  output logic                    bank_we_o,
  input  wire logic [31:0]        mach_rdata_i,
  input  wire logic               mach_hit_i,
  input  wire logic [31:0]        perf_rdata_i,
  input  wire logic               perf_hit_i
);

  localparam logic st_idle    = 1'b0;
  localparam logic st_respond = 1'b1;

  logic             state_q;
  logic             hold_q;      // response stalled past its first cycle
  logic [11:0]      addr_q;
  csr_pkg::csr_op_e op_q;
  logic [31:0]      wdata_q;
  logic [31:0]      rdata_q;     // old value frozen while stalled
  logic [31:0]      sel_rdata;
  logic             any_hit;
  logic             req_fire;
  logic             rsp_fire;

  assign req_ready_o = (state_q == st_idle);
  assign rsp_valid_o = (state_q == st_respond);
  assign req_fire    = req_valid_i & req_ready_o;
  assign rsp_fire    = rsp_valid_o & rsp_ready_i;

  //////////////////////////////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= st_idle;
      hold_q  <= 1'b0;
    end
    else
    begin
      if (req_fire)
        state_q <= st_respond;
      else if (rsp_fire)
        state_q <= st_idle;
      // freeze read data after the first response cycle
      hold_q <= rsp_valid_o & ~rsp_ready_i;
    end
  end

  // request payload, held for the whole access
  always_ff @(posedge clk)
  begin
    if (req_fire)
    begin
      addr_q  <= req_addr_i;
      op_q    <= req_op_i;
      wdata_q <= req_wdata_i;
    end
    if (rsp_valid_o && !hold_q)
      rdata_q <= sel_rdata;  // snapshot of the first response cycle
  end

  //////////////////////////////////////////////////////////////////////////
  // read select and read-modify-write
  //////////////////////////////////////////////////////////////////////////

  assign any_hit = mach_hit_i | perf_hit_i;

  always_comb
  begin
    sel_rdata = '0;  // unmapped reads as zero
    if (mach_hit_i)
      sel_rdata = mach_rdata_i;
    else if (perf_hit_i)
      sel_rdata = perf_rdata_i;
  end

  assign rsp_rdata_o = hold_q ? rdata_q : sel_rdata;
  assign rsp_err_o   = ~any_hit;

  always_comb
  begin
    unique case (op_q)
      csr_pkg::op_write: bank_wdata_o = wdata_q;
      csr_pkg::op_set:   bank_wdata_o = rsp_rdata_o | wdata_q;
      csr_pkg::op_clear: bank_wdata_o = rsp_rdata_o & ~wdata_q;
      default:           bank_wdata_o = rsp_rdata_o;  // op_none keeps old
    endcase
  end

  assign bank_addr_o = addr_q;
  // commit only on the response handshake, and never for an error
  assign bank_we_o   = rsp_fire & (op_q != csr_pkg::op_none) & any_hit;

  // payload must not move while the response waits
  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o && !rsp_ready_i |=>
      rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_err_o))
    else $error("response payload changed under back-pressure");

endmodule

`default_nettype wire

//--- hw/csr_pkg.sv
// Shared definitions for the CSR subsystem: access operations, CSR addresses,
// performance event positions and the mstatus word layout.
// Modules reach these by scoped names only.
`default_nettype none

package csr_pkg;

  // access operation, carried with each request
  typedef enum logic [1:0] {
    op_none  = 2'b00,  // plain read
    op_write = 2'b01,
    op_set   = 2'b10,  // old | wdata
    op_clear = 2'b11   // old & ~wdata
  } csr_op_e;

  // machine bank addresses
  localparam logic [11:0] addr_mstatus  = 12'h300;
  localparam logic [11:0] addr_mscratch = 12'h340;
  localparam logic [11:0] addr_mepc     = 12'h341;
  localparam logic [11:0] addr_mcpuid   = 12'hF00;  // read only
  localparam logic [11:0] addr_mimpid   = 12'hF01;  // read only
  localparam logic [11:0] addr_mhartid  = 12'hF10;  // read only

  // performance counter bank addresses
  localparam logic [11:0] addr_pcer      = 12'h7A0;  // event enable
  localparam logic [11:0] addr_pcmr      = 12'h7A1;  // mode, {saturate, global enable}
  localparam logic [11:0] addr_pccr_base = 12'h780;  // first counter
  localparam logic [11:0] addr_pccr_all  = 12'h79F;  // every counter at once

  // built-in events, bit positions in the event vector
  localparam int n_core_events = 9;
  localparam int evt_cycle     = 0;
  localparam int evt_instr     = 1;
  localparam int evt_ld_stall  = 2;
  localparam int evt_jr_stall  = 3;
  localparam int evt_imiss     = 4;
  localparam int evt_load      = 5;
  localparam int evt_store     = 6;
  localparam int evt_jump      = 7;
  localparam int evt_branch    = 8;

  // identity contents
  localparam logic [31:0] mcpuid_value = 32'h0000_0100;  // rv32i
  localparam logic [31:0] mimpid_value = 32'h0000_8000;

  // mstatus seen either as a raw word or as its fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [28:0] zero;  // unimplemented, reads 0
      logic [1:0]  prv;   // always machine mode, reads 3
      logic        ie;    // global interrupt enable
    } fld;
  } mstatus_word_u;

endpackage

`default_nettype wire
